//--- source/vmask_pkg.sv
// ####################
// Vector mask subset package.
// Element width encoding, mask and result types
// shared by the iota and reduce engines.
// ####################

package vmask_pkg;

  // ####################
  // Sizes.
  localparam int MASK_BITS  = 64;  // Widest mask per instruction.
  localparam int VL_BITS    = 7;   // Holds vl from 1 to 64.
  localparam int WORD_BITS  = 32;  // Result word width.
  localparam int BEAT_ELEMS = 8;   // Most elements in one iota beat.

  // ####################
  // Element width.
  typedef enum logic [1:0] {
    SEW8  = 2'b00,  // Eight elements per beat.
    SEW16 = 2'b01,  // Four elements per beat.
    SEW32 = 2'b10   // Two elements per beat.
  } sew_t;

  // ####################
  // Vectors with a meaning.
  typedef logic [MASK_BITS-1:0] mask_t;  // One bit per element.
  typedef logic [VL_BITS-1:0]   vl_t;    // Active element count.
  typedef logic [WORD_BITS-1:0] word_t;  // Result word.

  // Instruction operands, held by the driver.
  typedef struct packed {
    mask_t mask;  // Source mask.
    vl_t   vl;    // Vector length.
    sew_t  sew;   // Element width.
  } vmask_req_t;

  // One iota beat.
  typedef struct packed {
    word_t res0;  // Low packed elements.
    word_t res1;  // High packed elements.
    logic  last;  // Final beat of the instruction.
  } iota_beat_t;

  // Population count and find-first result.
  typedef struct packed {
    word_t popcount;  // Zero-extended count.
    word_t index;     // All ones when nothing found.
    logic  found;     // Some active bit was set.
  } reduce_res_t;

endpackage

//--- source/iota_unit.sv
// ####################
// Iota engine.
// Writes exclusive prefix counts of the mask, two to eight
// packed elements per beat, carrying count, sum and the
// remaining mask bits from one beat to the next.
// ####################

`timescale 1ns/1ps

module iota_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,  // Level, one beat per cycle.
  input  vmask_pkg::vmask_req_t req,    // Held stable by the driver.
  output vmask_pkg::iota_beat_t beat    // Valid while start is high.
);

  import vmask_pkg::*;

  // ####################
  // State carried across beats.
  vl_t   count_q;  // Elements consumed so far.
  word_t sum_q;    // Exclusive sum entering the beat.
  mask_t mask_q;   // Mask bits not yet consumed.

  // Beat datapath.
  mask_t      cur_mask;             // Mask seen by this beat.
  word_t      pre [BEAT_ELEMS+1];   // Prefix counts, pre[0] is the carry in.
  word_t      res0;                 // Packed low word.
  word_t      res1;                 // Packed high word.
  word_t      next_sum;             // Carry out to the next beat.
  logic [3:0] adv;                  // Elements in this beat.
  logic [7:0] next_count;           // Count after this beat, one bit wider.
  logic       done;                 // Instruction ends with this beat.

  // First beat reads the mask straight from the request.
  assign cur_mask = (count_q == '0) ? req.mask : mask_q;

  // ####################
  // Adder chain, one step per element.
  always_comb begin
    pre[0] = sum_q;  // Zero at the first beat.
    for (int k = 0; k < BEAT_ELEMS; k++) begin
      pre[k+1] = pre[k] + word_t'(cur_mask[k]);  // Add this element's bit.
    end
  end

  // ####################
  // Width select and packing, low element first.
  always_comb begin
    case (req.sew)
      SEW8: begin
        res0     = {pre[3][7:0], pre[2][7:0], pre[1][7:0], pre[0][7:0]};
        res1     = {pre[7][7:0], pre[6][7:0], pre[5][7:0], pre[4][7:0]};
        adv      = 4'd8;
        next_sum = pre[8];  // Value of element 8 onward.
      end
      SEW16: begin
        res0     = {pre[1][15:0], pre[0][15:0]};
        res1     = {pre[3][15:0], pre[2][15:0]};
        adv      = 4'd4;
        next_sum = pre[4];
      end
      default: begin
        // SEW32 and the unused code.
        res0     = pre[0];
        res1     = pre[1];
        adv      = 4'd2;
        next_sum = pre[2];
      end
    endcase
  end

  // End of instruction at vl or at the mask limit.
  assign next_count = 8'(count_q) + 8'(adv);
  assign done = (next_count >= 8'(req.vl)) || (next_count >= 8'(MASK_BITS));

  // ####################
  // Output, zero outside a beat.
  always_comb begin
    beat = '0;  // Idle value.
    if (start) begin
      beat.res0 = res0;
      beat.res1 = res1;
      beat.last = done;  // Flags the closing beat.
    end
  end

  // State update. Holds while start is low.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count_q <= '0;
      sum_q   <= '0;
      mask_q  <= '0;
    end else if (start) begin
      if (done) begin
        count_q <= '0;  // Next beat opens a new instruction.
        sum_q   <= '0;
        mask_q  <= '0;
      end else begin
        count_q <= next_count[VL_BITS-1:0];
        sum_q   <= next_sum;
        mask_q  <= cur_mask >> adv;  // Drop the consumed bits.
      end
    end
  end

endmodule

//--- source/mask_reduce.sv
// ####################
// Mask reduce engine.
// Population count and find-first over the mask bits
// below vl, registered one cycle after the start pulse.
// ####################

`timescale 1ns/1ps

module mask_reduce (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   start,  // One-cycle pulse, samples req.
  input  vmask_pkg::vmask_req_t  req,
  output vmask_pkg::reduce_res_t res,    // Held until the next pulse.
  output logic                   valid   // High one cycle after start.
);

  import vmask_pkg::*;

  // ####################
  // Active bits.
  mask_t       act_mask;   // Ones below vl.
  mask_t       hits;       // Set bits that count.
  vl_t         pop;        // Up to 64 fits in vl width.
  word_t       first_idx;  // Lowest hit or all ones.
  reduce_res_t res_d;      // Next result.
  reduce_res_t res_q;      // Registered result.
  logic        valid_q;

  // Full mask at 64 or beyond.
  assign act_mask = (req.vl >= vl_t'(MASK_BITS))
                    ? '1
                    : (mask_t'(1) << req.vl) - mask_t'(1);
  assign hits = req.mask & act_mask;

  // ####################
  // Population count.
  always_comb begin
    pop = '0;
    for (int i = 0; i < MASK_BITS; i++) begin
      pop = pop + vl_t'(hits[i]);  // One bit at a time.
    end
  end

  // Priority search, lowest index wins.
  always_comb begin
    first_idx = '1;  // Nothing found.
    for (int i = MASK_BITS - 1; i >= 0; i--) begin
      if (hits[i]) begin
        first_idx = word_t'(i);  // Lower bits overwrite.
      end
    end
  end

  // Result fields.
  always_comb begin
    res_d.popcount = word_t'(pop);  // Zero-extended.
    res_d.index    = first_idx;
    res_d.found    = |hits;
  end

  // ####################
  // Result register, loads only on start.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      res_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= start;  // Single-cycle strobe.
      if (start) begin
        res_q <= res_d;
      end
    end
  end

  assign res   = res_q;
  assign valid = valid_q;

endmodule

//--- source/vmask_unit.sv
// ####################
// Vector mask subset top.
// Feeds one request to the iota and reduce engines,
// each under its own strobe.
// ####################

`timescale 1ns/1ps

module vmask_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  vmask_pkg::vmask_req_t  req,           // Shared operands.
  input  logic                   iota_start,    // Level, one beat per cycle.
  input  logic                   reduce_start,  // One-cycle pulse.
  output vmask_pkg::iota_beat_t  iota_out,      // Combinational beat.
  output vmask_pkg::reduce_res_t reduce_out,    // Registered result.
  output logic                   reduce_valid   // One cycle after the pulse.
);

  // ####################
  // Iota engine.
  iota_unit u_iota (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (iota_start),
    .req   (req),
    .beat  (iota_out)
  );

  // ####################
  // Popcount and find-first engine.
  // Runs alongside iota.
  mask_reduce u_reduce (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (reduce_start),
    .req   (req),
    .res   (reduce_out),
    .valid (reduce_valid)
  );

endmodule

//--- sim/vmask_model.svh
// ####################
// Testbench reference model for the vector mask unit.
// LFSR source, golden iota prefix counts, expected
// reduce results and the per-cycle compare tasks.
// ####################

`ifndef VMASK_MODEL_SVH
`define VMASK_MODEL_SVH

// ####################
// Model state.
logic [31:0] lfsr_q;       // Random source state.
int          golden [64];  // Exclusive prefix count per element.
int          iota_idx;     // First element of the next beat.
reduce_res_t red_q [$];    // Results owed to reduce_valid.
logic        red_pend;     // A pulse went out last cycle.
reduce_res_t last_red;     // Value reduce_out must hold.

// Fibonacci form, x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // Tap XOR.
  return {s[30:0], fb};
endfunction

// One LFSR step per bit taken.
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v      = {v[62:0], lfsr_q[0]};  // Newest bit at the bottom.
  end
  return v;
endfunction

// ####################
// Beat geometry.
function automatic int beat_elems(input sew_t s);
  case (s)
    SEW8:    return 8;
    SEW16:   return 4;
    default: return 2;
  endcase
endfunction

function automatic int elem_width(input sew_t s);
  return 64 / beat_elems(s);  // Two 32-bit words per beat.
endfunction

// Prefix rule holds past vl too, so vl is not needed here.
task automatic load_golden(input vmask_req_t r);
  golden[0] = 0;
  for (int i = 1; i < 64; i++) begin
    golden[i] = golden[i-1] + int'(r.mask[i-1]);  // Bits strictly below i.
  end
endtask

// Packs the golden values of one beat, low element first.
function automatic iota_beat_t expect_beat(input vmask_req_t r, input int base);
  iota_beat_t  b;
  int          n;
  int          w;
  int          half;
  logic [31:0] v;
  n    = beat_elems(r.sew);
  w    = elem_width(r.sew);
  half = n / 2;  // Elements per word.
  b    = '0;
  for (int k = 0; k < n; k++) begin
    v = word_t'(golden[base+k]) & word_t'((64'd1 << w) - 64'd1);  // Truncate.
    if (k < half) begin
      b.res0 = b.res0 | (v << (k * w));
    end else begin
      b.res1 = b.res1 | (v << ((k - half) * w));
    end
  end
  b.last = (base + n >= int'(r.vl)) || (base + n >= 64);
  return b;
endfunction

// Popcount and first index below vl.
function automatic reduce_res_t expect_reduce(input vmask_req_t r);
  reduce_res_t e;
  e       = '0;
  e.index = '1;  // Nothing found yet.
  for (int i = 0; i < int'(r.vl) && i < 64; i++) begin
    if (r.mask[i]) begin
      e.popcount = e.popcount + 1;
      if (!e.found) begin
        e.index = i;
        e.found = 1'b1;
      end
    end
  end
  return e;
endfunction

// ####################
// Compare tasks, called at the falling edge.
task automatic check_iota();
  iota_beat_t exp;
  if (iota_start) begin
    if (iota_idx == 0) begin
      load_golden(req);  // New instruction.
    end
    exp = expect_beat(req, iota_idx);
    assert (iota_out == exp) else report_mismatch($sformatf(
      "iota beat at element %0d got %h expected %h", iota_idx, iota_out, exp));
    if (exp.last) begin
      iota_idx = 0;
    end else begin
      iota_idx = iota_idx + beat_elems(req.sew);
    end
  end else begin
    assert (iota_out == '0) else report_mismatch($sformatf(
      "iota_out %h while iota_start is low", iota_out));
  end
endtask

task automatic check_reduce();
  reduce_res_t exp;
  if (red_pend) begin
    exp = red_q.pop_front();
    assert (reduce_valid) else report_mismatch("reduce_valid low one cycle after its pulse");
    assert (reduce_out == exp) else report_mismatch($sformatf(
      "reduce_out %h expected %h", reduce_out, exp));
    last_red = exp;
  end else begin
    assert (!reduce_valid) else report_mismatch("reduce_valid high with no pulse before");
    assert (reduce_out == last_red) else report_mismatch($sformatf(
      "reduce_out %h did not hold %h", reduce_out, last_red));
  end
  red_pend = reduce_start;  // Owed next cycle.
  if (reduce_start) begin
    red_q.push_back(expect_reduce(req));
  end
endtask

`endif

//--- sim/vmask_unit_tb.sv
// ####################
// Testbench for the vector mask unit.
// Random iota, popcount and find-first instructions
// from an LFSR, checked against the included model.
// ####################

`timescale 1ns/1ps

module vmask_unit_tb;

  import vmask_pkg::*;

  // ####################
  // DUT signals.
  logic        CLK;
  logic        nRST;
  vmask_req_t  req;
  logic        iota_start;
  logic        reduce_start;
  iota_beat_t  iota_out;
  reduce_res_t reduce_out;
  logic        reduce_valid;

  vmask_unit UUT (
    .CLK          (CLK),
    .nRST         (nRST),
    .req          (req),
    .iota_start   (iota_start),
    .reduce_start (reduce_start),
    .iota_out     (iota_out),
    .reduce_out   (reduce_out),
    .reduce_valid (reduce_valid)
  );

  // 10 ns period.
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // ####################
  // Error exits.
  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic report_mismatch(input string what);
    $display("Mismatch at time %0t: %s", $time, what);
    abort_run();
  endtask

  `include "vmask_model.svh"

  // ####################
  // Stimulus helpers.
  function automatic sew_t sew_of(input int k);
    case (k)
      0:       return SEW8;
      1:       return SEW16;
      default: return SEW32;
    endcase
  endfunction

  function automatic sew_t rand_sew();
    return sew_of(int'(rand_bits(2) % 3));
  endfunction

  function automatic vmask_req_t random_req(input sew_t s, input int vl);
    vmask_req_t r;
    r.sew = s;
    r.vl  = vl_t'(vl);
    case (rand_bits(2))
      2'd0:    r.mask = rand_bits(64) & rand_bits(64);  // Sparse.
      2'd1:    r.mask = rand_bits(64) | rand_bits(64);  // Dense.
      default: r.mask = rand_bits(64);
    endcase
    return r;
  endfunction

  // One clock. Drive after the edge and check at the falling edge.
  task automatic drive_cycle(input vmask_req_t r, input logic io, input logic rd);
    @(posedge CLK);
    #1;
    req          = r;
    iota_start   = io;
    reduce_start = rd;
    @(negedge CLK);
    check_iota();
    check_reduce();
  endtask

  // Whole iota instruction with optional stalls and reduce traffic.
  task automatic run_iota(input vmask_req_t r, input bit stall, input bit burst);
    int   n;
    int   beats;
    int   done_beats;
    int   guard;
    logic io;
    logic rd;
    n          = beat_elems(r.sew);
    beats      = (int'(r.vl) + n - 1) / n;  // Rounded up.
    done_beats = 0;
    guard      = 0;
    while (done_beats < beats) begin
      io = 1'b1;
      rd = 1'b0;
      if (stall && done_beats > 0 && rand_bits(2) == 0) begin
        io = 1'b0;  // Gap mid-instruction.
      end
      if (burst) begin
        rd = (rand_bits(2) != 0);  // Mostly consecutive pulses.
      end
      drive_cycle(r, io, rd);
      if (io) begin
        done_beats++;
        assert (iota_out.last == (done_beats == beats)) else report_mismatch($sformatf(
          "last flag %0b on beat %0d of %0d", iota_out.last, done_beats, beats));
      end
      guard++;
      if (guard > 400) begin
        $display("Timeout: iota instruction did not finish in 400 cycles.");
        abort_run();
      end
    end
  endtask

  // Single pulse and a wait for its result.
  task automatic send_reduce(input vmask_req_t r);
    int   waited;
    logic seen;
    drive_cycle(r, 1'b0, 1'b1);
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < 16) begin
      drive_cycle(r, 1'b0, 1'b0);
      waited++;
      seen = reduce_valid;
    end
    if (!seen) begin
      $display("Timeout: reduce_valid never rose after reduce_start.");
      abort_run();
    end
  endtask

  // ####################
  // Main sequence.
  initial begin
    vmask_req_t r;
    int         n;
    int         vl;
    lfsr_q       = 32'h44c7_5b2b;
    iota_idx     = 0;
    red_pend     = 1'b0;
    last_red     = '0;
    nRST         = 1'b0;
    req          = '0;
    iota_start   = 1'b0;
    reduce_start = 1'b0;
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    assert (!reduce_valid) else report_mismatch("reduce_valid high after reset");
    assert (reduce_out == '0) else report_mismatch("reduce_out not zero after reset");
    assert (iota_out == '0) else report_mismatch("iota_out not zero after reset");

    // Iota with vl a whole number of beats.
    for (int s = 0; s < 3; s++) begin
      for (int t = 0; t < 4; t++) begin
        n  = beat_elems(sew_of(s));
        vl = n * (1 + int'(rand_bits(6)) % (64 / n));
        run_iota(random_req(sew_of(s), vl), 1'b0, 1'b0);
      end
    end

    // Partial last beat on back-to-back instructions.
    for (int t = 0; t < 9; t++) begin
      r  = random_req(rand_sew(), 1);
      n  = beat_elems(r.sew);
      vl = 1 + int'(rand_bits(6));
      if (vl % n == 0 && vl < 64) begin
        vl = vl - 1;  // Force a short beat.
      end
      r.vl = vl_t'(vl);
      run_iota(r, 1'b0, 1'b0);
    end
    for (int s = 0; s < 3; s++) begin
      run_iota(random_req(sew_of(s), 64), 1'b0, 1'b0);  // Mask limit.
    end

    // Stalls.
    for (int t = 0; t < 6; t++) begin
      run_iota(random_req(rand_sew(), 1 + int'(rand_bits(6))), 1'b1, 1'b0);
    end

    // Popcount and find-first with single pulses.
    for (int t = 0; t < 24; t++) begin
      vl = 1 + int'(rand_bits(6) % 63);  // 1 to 63.
      r  = random_req(rand_sew(), vl);
      case (t % 4)
        0:       r.mask = '0;
        1:       r.mask = r.mask & ~((64'd1 << vl) - 64'd1);  // Only at or above vl.
        3:       r.vl   = vl_t'(64);
        default: r.mask = r.mask;
      endcase
      send_reduce(r);
    end

    // Back-to-back pulses with new operands each cycle.
    for (int t = 0; t < 8; t++) begin
      drive_cycle(random_req(rand_sew(), 1 + int'(rand_bits(6))), 1'b0, 1'b1);
    end
    drive_cycle(req, 1'b0, 1'b0);

    // Reduce bursts while iota runs.
    for (int t = 0; t < 4; t++) begin
      run_iota(random_req(rand_sew(), 1 + int'(rand_bits(6))), t[0], 1'b1);
    end
    repeat (2) drive_cycle(req, 1'b0, 1'b0);  // Drain the last result.

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- compile.f
+incdir+sim
source/vmask_pkg.sv
source/iota_unit.sv
source/mask_reduce.sv
source/vmask_unit.sv
sim/vmask_unit_tb.sv

//--- Bender.yml
package:
  name: vmask_unit

sources:
  # Package first, then the engines and the top level.
  - files:
      - source/vmask_pkg.sv
      - source/iota_unit.sv
      - source/mask_reduce.sv
      - source/vmask_unit.sv

  # Testbench with its included model.
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/vmask_unit_tb.sv
